// ==== design/conv_pkg.sv ====
package conv_pkg;

   ////////////////////
   // sizes
   localparam int IDX_W              = 16;
   localparam int PIXELS_IN_ROW      = 32;
   localparam int PIXELS_IN_ROW_LOG2 = 5;
   localparam int BUFFER_ROWS        = 3;
   localparam int ROWS_MODE0         = 64;
   localparam int ROWS_MODE1         = 128;

   typedef logic [IDX_W-1:0] idx_t;

   // row in padding or past the tile edge
   localparam idx_t INVALID_IDX = '1;

   ////////////////////
   // register map, word addresses
   localparam logic [3:0] CFG_SIZE_ADR   = 4'd0;
   localparam logic [3:0] CFG_IN_ADR     = 4'd1;
   localparam logic [3:0] CFG_KERNEL_ADR = 4'd2;
   localparam logic [3:0] CFG_CHAN_ADR   = 4'd3;
   localparam logic [3:0] CTRL_ADR       = 4'd4;
   localparam logic [3:0] STATUS_ADR     = 4'd5;

   typedef struct packed {
      logic       mode;
      idx_t       of;
      idx_t       ox;
      idx_t       oy;
      idx_t       ix;
      idx_t       iy;
      idx_t       nif;
      logic [3:0] k;
      logic [3:0] s;
      logic [3:0] p;
   } conv_cfg_t;

   typedef struct packed {
      idx_t oy_start;
      idx_t ox_start;
      idx_t of_start;
      idx_t poy;
      idx_t pox;
      idx_t pof;
   } tile_pos_t;

   typedef struct packed {
      logic                         valid;
      idx_t [BUFFER_ROWS-1:0]       row_idx;
      logic [BUFFER_ROWS-1:0]       row_valid;
      idx_t                         row_start;
      idx_t                         row_end;
      idx_t                         reg_start;
      idx_t                         reg_end;
      logic [3:0]                   west_pad;
      logic [3:0]                   east_pad;
      idx_t                         if_idx;
      logic                         last;
   } row_req_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  adr;
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

endpackage

// ==== design/conv_cfg_regs.sv ====
`timescale 1ns/1ns

module conv_cfg_regs (
   input  logic                clk,
   input  logic                reset,
   input  conv_pkg::wb_req_t   wb_req,
   output conv_pkg::wb_rsp_t   wb_rsp,
   input  logic                conv_done,
   output conv_pkg::conv_cfg_t cfg,
   output logic                start
);
   import conv_pkg::*;

   logic [31:0] size_reg;
   logic [31:0] in_reg;
   logic [31:0] kernel_reg;
   logic [31:0] chan_reg;
   logic [31:0] rd_data;
   logic [31:0] rdat_q;
   logic        ack_q;
   logic        busy;
   logic        done;
   logic        access;
   logic        wr_commit;
   logic        start_cmd;

   // new access rises ack, write takes effect in the ack cycle
   assign access    = wb_req.cyc && wb_req.stb && !ack_q;
   assign wr_commit = wb_req.cyc && wb_req.stb && wb_req.we && ack_q;
   assign start_cmd = wr_commit && (wb_req.adr == CTRL_ADR) && wb_req.dat[0] && !busy;

   always_comb begin
      case (wb_req.adr)
         CFG_SIZE_ADR:   rd_data = size_reg;
         CFG_IN_ADR:     rd_data = in_reg;
         CFG_KERNEL_ADR: rd_data = kernel_reg;
         CFG_CHAN_ADR:   rd_data = chan_reg;
         STATUS_ADR:     rd_data = {30'd0, done, busy};
         default:        rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdat_q <= rd_data;
      end
   end

   assign wb_rsp = '{ack: ack_q, dat: rdat_q};

   ////////////////////
   // layer registers
   always_ff @(posedge clk) begin
      if (wr_commit) begin
         case (wb_req.adr)
            CFG_SIZE_ADR:   size_reg   <= wb_req.dat;
            CFG_IN_ADR:     in_reg     <= wb_req.dat;
            CFG_KERNEL_ADR: kernel_reg <= wb_req.dat;
            CFG_CHAN_ADR:   chan_reg   <= wb_req.dat;
            default:        ;
         endcase
      end
   end

   assign cfg.ox   = size_reg[15:0];
   assign cfg.oy   = size_reg[31:16];
   assign cfg.ix   = in_reg[15:0];
   assign cfg.iy   = in_reg[31:16];
   assign cfg.k    = kernel_reg[3:0];
   assign cfg.s    = kernel_reg[7:4];
   assign cfg.p    = kernel_reg[11:8];
   assign cfg.mode = kernel_reg[12];
   assign cfg.of   = chan_reg[15:0];
   assign cfg.nif  = chan_reg[31:16];

   // start pulse and status
   always_ff @(posedge clk) begin
      if (reset) begin
         start <= 1'b0;
         busy  <= 1'b0;
         done  <= 1'b0;
      end else begin
         start <= start_cmd;
         if (start_cmd) begin
            busy <= 1'b1;
            done <= 1'b0;
         end else if (conv_done) begin
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

endmodule

// ==== design/tile_loop_nest.sv ====
`timescale 1ns/1ns

module tile_loop_nest (
   input  logic                clk,
   input  logic                reset,
   input  conv_pkg::conv_cfg_t cfg,
   input  logic                start,
   input  logic                kernel_end,
   input  logic                drain_done,
   output conv_pkg::tile_pos_t tile,
   output conv_pkg::tile_pos_t cur_tile,
   output conv_pkg::idx_t      if_idx,
   output logic                drain_wait,
   output logic                conv_done
);
   import conv_pkg::*;

   idx_t if_cnt;
   idx_t f_start;
   idx_t x_start;
   idx_t y_start;
   idx_t f_step;
   logic if_last;
   logic f_last;
   logic x_last;
   logic y_last;

   assign f_step = cfg.mode ? idx_t'(ROWS_MODE1) : idx_t'(ROWS_MODE0);

   // loop ends, inner to outer
   assign if_last = kernel_end && (if_cnt >= cfg.nif);
   assign f_last  = if_last && (f_start + f_step > cfg.of);
   assign x_last  = f_last && (x_start + PIXELS_IN_ROW > cfg.ox);
   assign y_last  = x_last && (y_start + BUFFER_ROWS > cfg.oy);

   always_ff @(posedge clk) begin
      if (reset || start) begin
         if_cnt  <= idx_t'(1);
         f_start <= idx_t'(1);
         x_start <= idx_t'(1);
         y_start <= idx_t'(1);
      end else begin
         if (kernel_end) begin
            if_cnt <= if_last ? idx_t'(1) : idx_t'(if_cnt + 1);
         end
         if (if_last) begin
            f_start <= f_last ? idx_t'(1) : idx_t'(f_start + f_step);
         end
         if (f_last) begin
            x_start <= x_last ? idx_t'(1) : idx_t'(x_start + PIXELS_IN_ROW);
         end
         if (x_last) begin
            y_start <= y_last ? idx_t'(1) : idx_t'(y_start + BUFFER_ROWS);
         end
      end
   end

   ////////////////////
   // live tile, edge tiles get the remainder
   assign tile.oy_start = y_start;
   assign tile.ox_start = x_start;
   assign tile.of_start = f_start;
   assign tile.poy = (y_start + BUFFER_ROWS - 1 > cfg.oy) ?
                     idx_t'(cfg.oy - y_start + 1) : idx_t'(BUFFER_ROWS);
   assign tile.pox = (x_start + PIXELS_IN_ROW - 1 > cfg.ox) ?
                     idx_t'(cfg.ox - x_start + 1) : idx_t'(PIXELS_IN_ROW);
   assign tile.pof = (f_start + f_step - 1 > cfg.of) ?
                     idx_t'(cfg.of - f_start + 1) : f_step;

   assign if_idx    = if_cnt;
   assign conv_done = y_last;

   // drain stall after every channel tile
   always_ff @(posedge clk) begin
      if (reset) begin
         drain_wait <= 1'b0;
      end else if (if_last) begin
         drain_wait <= 1'b1;
      end else if (drain_done) begin
         drain_wait <= 1'b0;
      end
   end

   // tile copy for the output side, frozen while it drains
   always_ff @(posedge clk) begin
      if (reset) begin
         cur_tile <= '0;
      end else if (!drain_wait || drain_done) begin
         cur_tile <= tile;
      end
   end

   if_in_range: assert property (@(posedge clk) disable iff (reset)
      kernel_end |-> (if_cnt <= cfg.nif));

   no_step_in_drain: assert property (@(posedge clk) disable iff (reset)
      !(drain_wait && kernel_end));

endmodule

// ==== design/kernel_row_window.sv ====
`timescale 1ns/1ns

module kernel_row_window (
   input  logic                                       clk,
   input  logic                                       reset,
   input  conv_pkg::conv_cfg_t                        cfg,
   input  conv_pkg::tile_pos_t                        tile,
   input  logic                                       row_end,
   output conv_pkg::idx_t [conv_pkg::BUFFER_ROWS-1:0] row_idx,
   output logic [conv_pkg::BUFFER_ROWS-1:0]           row_valid,
   output logic                                       kernel_end
);
   import conv_pkg::*;

   idx_t                   ky;
   idx_t                   iy_start;
   idx_t                   p_ext;
   idx_t                   s_ext;
   idx_t [BUFFER_ROWS-1:0] row_in;

   assign p_ext = idx_t'(cfg.p);
   assign s_ext = idx_t'(cfg.s);

   // first input row of the tile in padded coordinates
   assign iy_start = (cfg.s == 4'd2) ? idx_t'((tile.oy_start << 1) - 1) : tile.oy_start;

   assign kernel_end = row_end && (ky + 1 >= idx_t'(cfg.k));

   always_ff @(posedge clk) begin
      if (reset) begin
         ky <= '0;
      end else if (row_end) begin
         ky <= kernel_end ? '0 : idx_t'(ky + 1);
      end
   end

   // one input row per buffer row
   always_comb begin
      for (int r = 0; r < BUFFER_ROWS; r++) begin
         row_in[r]    = idx_t'(iy_start + idx_t'(r) * s_ext + ky);
         row_valid[r] = idx_t'(r) < tile.poy;
         if (!row_valid[r] || (row_in[r] < p_ext + 1) || (row_in[r] > p_ext + cfg.iy)) begin
            row_idx[r] = INVALID_IDX;
         end else begin
            row_idx[r] = idx_t'(row_in[r] - p_ext);
         end
      end
   end

endmodule

// ==== design/row_word_walker.sv ====
`timescale 1ns/1ns

module row_word_walker (
   input  logic                clk,
   input  logic                reset,
   input  conv_pkg::conv_cfg_t cfg,
   input  conv_pkg::tile_pos_t tile,
   input  logic                start,
   input  logic                drain_wait,
   input  logic                conv_done,
   output conv_pkg::row_req_t  req,
   output logic                row_end
);
   import conv_pkg::*;

   idx_t       p_ext;
   idx_t       k_ext;
   idx_t       ix_start;
   idx_t       ix_end;
   idx_t       span;
   idx_t       left_pad;
   idx_t       right_pad;
   idx_t       overlap;
   idx_t       row_first;
   idx_t       row_last_raw;
   idx_t       row_last_up;
   idx_t       row_last;
   idx_t       reg_init;
   idx_t       word_start;
   idx_t       word_span;
   idx_t       adr;
   idx_t       row_len;
   logic [3:0] stall_cnt;
   logic       active;
   logic       step;
   logic       is_last;

   assign p_ext = idx_t'(cfg.p);
   assign k_ext = idx_t'(cfg.k);

   ////////////////////
   // input column range of the tile
   assign ix_start = (cfg.s == 4'd2) ? idx_t'((tile.ox_start << 1) - 1) : tile.ox_start;
   assign span     = (cfg.s == 4'd2) ? idx_t'((tile.pox - 1) << 1) : idx_t'(tile.pox - 1);
   assign ix_end   = idx_t'(ix_start + span + k_ext - 1);

   assign left_pad  = (ix_start <= p_ext) ? idx_t'(p_ext - ix_start + 1) : '0;
   assign right_pad = (ix_end > p_ext + cfg.ix) ? idx_t'(ix_end - (p_ext + cfg.ix)) : '0;
   assign overlap   = (ix_start > p_ext + 1) ? p_ext : '0;

   // unpadded pixel range, end rounded up to a whole word
   assign row_first    = idx_t'(ix_start + left_pad - (p_ext + 1) + overlap);
   assign row_last_raw = idx_t'(ix_end - right_pad - (p_ext + 1));
   assign row_last_up  = idx_t'((((row_last_raw >> PIXELS_IN_ROW_LOG2) + 1)
                                 << PIXELS_IN_ROW_LOG2) - 1);
   assign row_last     = (row_last_up > cfg.ix - 1) ? idx_t'(cfg.ix - 1) : row_last_up;
   assign reg_init     = idx_t'(left_pad + overlap + 1);

   // current word
   assign word_start = idx_t'(row_first + adr);
   assign word_span  = (word_start + PIXELS_IN_ROW - 1 > row_last_raw) ?
                       idx_t'(row_last_raw - word_start) : idx_t'(PIXELS_IN_ROW - 1);
   assign is_last    = (adr + PIXELS_IN_ROW > row_last - row_first);
   assign step       = active && (stall_cnt == '0) && !drain_wait;
   assign row_end    = step && is_last;

   always_ff @(posedge clk) begin
      if (reset) begin
         active <= 1'b0;
      end else if (start) begin
         active <= 1'b1;
      end else if (conv_done) begin
         active <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || start) begin
         adr     <= '0;
         row_len <= idx_t'(1);
      end else if (step) begin
         adr     <= is_last ? '0 : idx_t'(adr + PIXELS_IN_ROW);
         row_len <= is_last ? idx_t'(1) : idx_t'(row_len + 1);
      end
   end

   // short rows are padded out to k cycles
   always_ff @(posedge clk) begin
      if (reset || start) begin
         stall_cnt <= '0;
      end else if (row_end) begin
         if (conv_done || (k_ext <= row_len)) begin
            stall_cnt <= '0;
         end else begin
            stall_cnt <= 4'(k_ext - row_len);
         end
      end else if (stall_cnt != '0) begin
         stall_cnt <= stall_cnt - 4'd1;
      end
   end

   ////////////////////
   // request, rows and channel filled in at the top
   always_comb begin
      req           = '0;
      req.valid     = step;
      req.row_start = word_start;
      req.row_end   = (word_start + PIXELS_IN_ROW - 1 > row_last) ?
                      row_last : idx_t'(word_start + PIXELS_IN_ROW - 1);
      req.west_pad  = (adr == '0) ? left_pad[3:0] : 4'd0;
      req.east_pad  = is_last ? right_pad[3:0] : 4'd0;
      req.reg_start = idx_t'(reg_init + adr);
      req.reg_end   = idx_t'(reg_init + adr + word_span + idx_t'(req.east_pad));
      req.last      = is_last;
   end

endmodule

// ==== design/conv_router.sv ====
`timescale 1ns/1ns

module conv_router (
   input  logic                clk,
   input  logic                reset,
   input  conv_pkg::wb_req_t   wb_req,
   output conv_pkg::wb_rsp_t   wb_rsp,
   input  logic                drain_done,
   output conv_pkg::row_req_t  req,
   output conv_pkg::tile_pos_t cur_tile,
   output logic                tile_drain
);
   import conv_pkg::*;

   conv_cfg_t              cfg;
   tile_pos_t              tile;
   row_req_t               walk_req;
   idx_t                   if_idx;
   idx_t [BUFFER_ROWS-1:0] row_idx;
   logic [BUFFER_ROWS-1:0] row_valid;
   logic                   start;
   logic                   conv_done;
   logic                   kernel_end;
   logic                   row_end;
   logic                   drain_wait;

   conv_cfg_regs u_regs (
      .clk       (clk),
      .reset     (reset),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .conv_done (conv_done),
      .cfg       (cfg),
      .start     (start)
   );

   tile_loop_nest u_tiles (
      .clk        (clk),
      .reset      (reset),
      .cfg        (cfg),
      .start      (start),
      .kernel_end (kernel_end),
      .drain_done (drain_done),
      .tile       (tile),
      .cur_tile   (cur_tile),
      .if_idx     (if_idx),
      .drain_wait (drain_wait),
      .conv_done  (conv_done)
   );

   kernel_row_window u_rows (
      .clk        (clk),
      .reset      (reset),
      .cfg        (cfg),
      .tile       (tile),
      .row_end    (row_end),
      .row_idx    (row_idx),
      .row_valid  (row_valid),
      .kernel_end (kernel_end)
   );

   row_word_walker u_words (
      .clk        (clk),
      .reset      (reset),
      .cfg        (cfg),
      .tile       (tile),
      .start      (start),
      .drain_wait (drain_wait),
      .conv_done  (conv_done),
      .req        (walk_req),
      .row_end    (row_end)
   );

   // merge row window and channel into the request
   always_comb begin
      req           = walk_req;
      req.row_idx   = row_idx;
      req.row_valid = row_valid;
      req.if_idx    = if_idx;
   end

   assign tile_drain = drain_wait;

endmodule

// ==== sim/tb_conv_router.sv ====
`timescale 1ns/1ns

module tb_conv_router;
   import conv_pkg::*;

   typedef struct packed {
      conv_cfg_t cfg;
      int        requests;
      int        drains;
      int        row_start;
      int        west_pad;
      int        row0;
      int        row1;
      int        row2;
   } test_case_t;

   logic       clk;
   logic       reset;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic       drain_done;
   row_req_t   req;
   tile_pos_t  cur_tile;
   logic       tile_drain;

   test_case_t cases[$];
   test_case_t cur_case;
   integer     seed = 32'hb21e_5530;
   int         error_count;
   int         check_count;
   int         req_count;
   int         drain_count;
   int         cycle_count;
   int         cycle_limit;
   logic       first_pending = 1'b0;
   logic       drain_prev = 1'b0;

   // tile model, stepped on each drain
   int         tile_y;
   int         tile_x;
   int         tile_f;
   tile_pos_t  exp_tile;

   conv_router UUT (
      .clk        (clk),
      .reset      (reset),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .drain_done (drain_done),
      .req        (req),
      .cur_tile   (cur_tile),
      .tile_drain (tile_drain)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("Fail at time %0t: %s expected %0d actual %0d", $time, name, expected, actual);
      end
   endtask

   // east padding of the last word, from the tile's input column range
   function automatic int right_pad_of(input conv_cfg_t c, input tile_pos_t t);
      int ix_start;
      int ix_end;
      ix_start = (c.s == 4'd2) ? 2 * int'(t.ox_start) - 1 : int'(t.ox_start);
      ix_end   = ix_start + (int'(t.pox) - 1) * int'(c.s) + int'(c.k) - 1;
      if (ix_end > int'(c.p) + int'(c.ix)) begin
         return ix_end - (int'(c.p) + int'(c.ix));
      end else begin
         return 0;
      end
   endfunction

   // full step, or what is left at the layer edge
   function automatic tile_pos_t tile_at(input conv_cfg_t c, input int y, input int x,
                                         input int f);
      tile_pos_t t;
      int        f_size;
      int        left;
      f_size     = c.mode ? ROWS_MODE1 : ROWS_MODE0;
      t.oy_start = idx_t'(y);
      t.ox_start = idx_t'(x);
      t.of_start = idx_t'(f);
      left       = int'(c.oy) - y + 1;
      t.poy      = idx_t'((left < BUFFER_ROWS) ? left : BUFFER_ROWS);
      left       = int'(c.ox) - x + 1;
      t.pox      = idx_t'((left < PIXELS_IN_ROW) ? left : PIXELS_IN_ROW);
      left       = int'(c.of) - f + 1;
      t.pof      = idx_t'((left < f_size) ? left : f_size);
      return t;
   endfunction

   // channel tile innermost, then column, then row
   task automatic next_tile();
      int f_size;
      f_size = cur_case.cfg.mode ? ROWS_MODE1 : ROWS_MODE0;
      tile_f += f_size;
      if (tile_f > int'(cur_case.cfg.of)) begin
         tile_f = 1;
         tile_x += PIXELS_IN_ROW;
         if (tile_x > int'(cur_case.cfg.ox)) begin
            tile_x = 1;
            tile_y += BUFFER_ROWS;
            if (tile_y > int'(cur_case.cfg.oy)) begin
               tile_y = 1;
            end
         end
      end
      exp_tile = tile_at(cur_case.cfg, tile_y, tile_x, tile_f);
   endtask

   task automatic check_tile(input tile_pos_t t);
      check_value("cur_tile.oy_start", t.oy_start, cur_tile.oy_start);
      check_value("cur_tile.ox_start", t.ox_start, cur_tile.ox_start);
      check_value("cur_tile.of_start", t.of_start, cur_tile.of_start);
      check_value("cur_tile.poy", t.poy, cur_tile.poy);
      check_value("cur_tile.pox", t.pox, cur_tile.pox);
      check_value("cur_tile.pof", t.pof, cur_tile.pof);
   endtask

   ////////////////////
   // wishbone master
   task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      @(posedge clk);
      #1;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdata;
      do begin
         @(posedge clk);
         #1;
      end while (!wb_rsp.ack);
      rdata = wb_rsp.dat;
      // hold through the ack cycle, then release
      @(posedge clk);
      #1;
      wb_req = '0;
      check_value("wb_rsp.ack", 0, wb_rsp.ack);
   endtask

   task automatic bus_write(input logic [3:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic bus_read(input logic [3:0] adr, output logic [31:0] data);
      bus_cycle(1'b0, adr, 32'd0, data);
   endtask

   task automatic load_cases();
      int         fd;
      int         n;
      int         v [17];
      string      line;
      test_case_t tc;
      fd = $fopen("sim/conv_router_testdata.txt", "r");
      if (fd == 0) begin
         error_count++;
         $display("could not open the test data file");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                        v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
            if (n == 17) begin
               tc.cfg.mode   = (v[0] != 0);
               tc.cfg.of     = idx_t'(v[1]);
               tc.cfg.ox     = idx_t'(v[2]);
               tc.cfg.oy     = idx_t'(v[3]);
               tc.cfg.ix     = idx_t'(v[4]);
               tc.cfg.iy     = idx_t'(v[5]);
               tc.cfg.nif    = idx_t'(v[6]);
               tc.cfg.k      = 4'(v[7]);
               tc.cfg.s      = 4'(v[8]);
               tc.cfg.p      = 4'(v[9]);
               tc.requests   = v[10];
               tc.drains     = v[11];
               tc.row_start  = v[12];
               tc.west_pad   = v[13];
               tc.row0       = v[14];
               tc.row1       = v[15];
               tc.row2       = v[16];
               cases.push_back(tc);
               cycle_limit += tc.requests * (v[7] + 2) + 200 * tc.drains;
            end else begin
               error_count++;
               $display("a test data line has the wrong number of fields");
            end
         end
      end
      $fclose(fd);
      if (cases.size() == 0) begin
         error_count++;
         $display("the test data file holds no test cases");
      end
   endtask

   task automatic run_case(input int i);
      logic [31:0] rdata;
      logic [31:0] regs [4];
      logic [3:0]  adrs [4];
      cur_case = cases[i];
      adrs[0] = CFG_SIZE_ADR;
      adrs[1] = CFG_IN_ADR;
      adrs[2] = CFG_KERNEL_ADR;
      adrs[3] = CFG_CHAN_ADR;
      regs[0] = {cur_case.cfg.oy, cur_case.cfg.ox};
      regs[1] = {cur_case.cfg.iy, cur_case.cfg.ix};
      regs[2] = {19'd0, cur_case.cfg.mode, cur_case.cfg.p, cur_case.cfg.s, cur_case.cfg.k};
      regs[3] = {cur_case.cfg.nif, cur_case.cfg.of};
      for (int a = 0; a < 4; a++) begin
         bus_write(adrs[a], regs[a]);
      end
      for (int a = 0; a < 4; a++) begin
         bus_read(adrs[a], rdata);
         check_value($sformatf("wb_rsp.dat at adr %0d", adrs[a]), regs[a], rdata);
      end
      req_count     = 0;
      drain_count   = 0;
      tile_y        = 1;
      tile_x        = 1;
      tile_f        = 1;
      exp_tile      = tile_at(cur_case.cfg, 1, 1, 1);
      first_pending = 1'b1;
      bus_write(CTRL_ADR, 32'd1);
      // poll until done
      do begin
         bus_read(STATUS_ADR, rdata);
      end while (!rdata[1]);
      check_value("status.busy", 0, rdata[0]);
      while (tile_drain) begin
         @(posedge clk);
         #1;
      end
      @(negedge clk);
      check_value("request count", cur_case.requests, req_count);
      check_value("tile_drain rises", cur_case.drains, drain_count);
      check_value("first request missing", 0, first_pending);
   endtask

   ////////////////////
   // request monitor, mid cycle
   always @(negedge clk) begin
      if (!reset) begin
         if (tile_drain && !drain_prev) begin
            drain_count++;
            check_tile(exp_tile);
            next_tile();
         end
         drain_prev = tile_drain;
         if (tile_drain) begin
            check_value("req.valid", 0, req.valid);
         end
         if (req.valid) begin
            req_count++;
            for (int r = 0; r < BUFFER_ROWS; r++) begin
               if (req.row_idx[r] != INVALID_IDX) begin
                  check_value($sformatf("req.row_idx[%0d] in 1..iy", r), 1,
                              (req.row_idx[r] >= 1) && (req.row_idx[r] <= cur_case.cfg.iy));
               end
               if (r >= exp_tile.poy) begin
                  check_value($sformatf("req.row_valid[%0d]", r), 0, req.row_valid[r]);
               end
            end
            if (req.last) begin
               check_value("req.east_pad", right_pad_of(cur_case.cfg, exp_tile), req.east_pad);
            end
            if (first_pending) begin
               check_value("req.row_start", cur_case.row_start, req.row_start);
               check_value("req.west_pad", cur_case.west_pad, req.west_pad);
               check_value("req.row_idx[0]", cur_case.row0, req.row_idx[0]);
               check_value("req.row_idx[1]", cur_case.row1, req.row_idx[1]);
               check_value("req.row_idx[2]", cur_case.row2, req.row_idx[2]);
               first_pending = 1'b0;
            end
         end
      end
   end

   // output side answers each drain after a random wait
   initial begin
      int delay;
      forever begin
         @(posedge clk);
         #1;
         if (!reset && tile_drain) begin
            delay = {$random(seed)} % 16;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            drain_done = 1'b1;
            @(posedge clk);
            #1;
            drain_done = 1'b0;
         end
      end
   end

   initial begin
      #1;
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      reset      = 1'b1;
      wb_req     = '0;
      drain_done = 1'b0;
      load_cases();
      if (cases.size() != 0) begin
         repeat (8) @(posedge clk);
         #1;
         reset = 1'b0;
         foreach (cases[i]) begin
            run_case(i);
         end
      end
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== sim/conv_router_testdata.txt ====
# mode of ox oy ix iy nif k s p | requests drains | first request: row_start west_pad row0 row1 row2
# a row index of 65535 marks a row in the padding or past the tile
# stride 1, one tile, padding 1
0 64 8 3 8 3 2 3 1 1 6 1 0 1 65535 1 2
# stride 2, two row tiles, two words per row
0 32 20 5 40 10 1 3 2 1 12 2 0 1 65535 2 4
# mode 1, two channel tiles, 1x1 kernel
1 200 4 3 4 3 2 1 1 0 4 2 0 0 1 2 3
# two column tiles, two channel tiles, short row tile
0 100 40 2 42 4 1 3 1 1 18 4 0 1 65535 1 65535
# stride 2, padding 2, kernel 5
1 128 6 4 12 8 1 5 2 2 10 2 0 2 65535 1 3
# three column tiles, east padding on the last
0 64 70 3 70 3 1 3 1 1 15 3 0 1 65535 1 2
# mode 1, three row tiles, three input channels
1 128 10 7 11 8 3 2 1 0 18 3 0 0 1 2 3
# stride 2, no padding, two channel tiles
0 65 3 3 7 7 1 3 2 0 6 2 0 0 1 3 5

// ==== src.f ====
design/conv_pkg.sv
design/conv_cfg_regs.sv
design/tile_loop_nest.sv
design/kernel_row_window.sv
design/row_word_walker.sv
design/conv_router.sv
sim/tb_conv_router.sv

// ==== Bender.yml ====
package:
  name: conv_router

sources:
  - design/conv_pkg.sv
  - design/conv_cfg_regs.sv
  - design/tile_loop_nest.sv
  - design/kernel_row_window.sv
  - design/row_word_walker.sv
  - design/conv_router.sv
  - target: simulation
    files:
      - sim/tb_conv_router.sv
